// ==== nes_bus_pkg.sv ====
// Holds the register map of the stock console with no mirrors in 4000-401F. CPU_DIV_DEFAULT is for NTSC.
package nes_bus_pkg;

	// Bus widths
	typedef logic [15:0] addr_t; // CPU address
	typedef logic [7:0]  byte_t; // Data byte

	// Sprite DMA registers
	localparam addr_t SPRITE_DMA_ADDR = 16'h4014; // Write the page here to start sprite DMA
	localparam addr_t OAM_DATA_ADDR   = 16'h2004; // Sink of every sprite DMA write

	// APU and joypad registers
	localparam addr_t APU_STATUS_ADDR = 16'h4015; // Only readable APU register
	localparam addr_t JOY1_ADDR       = 16'h4016; // Port 1, the strobe latch on write
	localparam addr_t JOY2_ADDR       = 16'h4017; // Port 2

	// Register windows, the end is exclusive
	localparam addr_t APU_BASE = 16'h4000;
	localparam addr_t APU_END  = 16'h4018;
	localparam addr_t PPU_BASE = 16'h2000;
	localparam addr_t PPU_END  = 16'h4000;

	// Joypad widths
	localparam int JOY_BITS     = 5; // Data bits that a joypad drives, the rest is open bus
	localparam int JOY_OUT_BITS = 3; // Strobe and expansion outputs

	// Sprite DMA state
	// Bit 0 means the CPU is held and bit 1 means the DMA owns the bus
	typedef enum logic [1:0] {
		SPR_IDLE   = 2'b00,
		SPR_ARMED  = 2'b01, // Waiting for an odd read tick
		SPR_ACTIVE = 2'b11  // Moving bytes
	} spr_state_t;

	// Master clocks per CPU tick
	localparam int CPU_DIV_DEFAULT = 12;

endpackage

// ==== cpu_bus_if.sv ====
// Merged CPU/DMA bus. At most one of rd and wr is high in a tick, and both hold for the whole tick.
`timescale 1ns/1ps

interface cpu_bus_if;
	import nes_bus_pkg::*;

	addr_t addr;  // Address after the DMA merge
	byte_t wdata; // Write data after the DMA merge
	logic  rd;    // Read tick
	logic  wr;    // Write tick

	// DMA controller owns the merge
	modport master (
		output addr,
		output wdata,
		output rd,
		output wr
	);

	// Decoder and read mux only look
	modport observer (
		input addr,
		input wdata,
		input rd,
		input wr
	);

endinterface

// ==== cpu_clock_divider.sv ====
// CPU_DIV must be even and at least 2. The first cpu_ce comes CPU_DIV clocks after reset falls.
`timescale 1ns/1ps

module cpu_clock_divider #(
	parameter int CPU_DIV = nes_bus_pkg::CPU_DIV_DEFAULT // Master clocks per CPU tick
) (
	input  logic clk,
	input  logic reset,
	output logic cpu_ce,    // One clock wide, once per tick
	output logic odd_cycle  // 1 on odd ticks, APU half rate
);

	localparam int CNT_W = $clog2(CPU_DIV);

	logic [CNT_W-1:0] div_cnt; // Master clocks into the current tick

	// Last clock of the tick
	assign cpu_ce = (div_cnt == CNT_W'(CPU_DIV - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cnt   <= '0;
			odd_cycle <= 1'b1; // First tick after reset counts as odd
		end else begin
			div_cnt <= cpu_ce ? '0 : div_cnt + 1'b1; // Wrap at CPU_DIV
			if (cpu_ce)
				odd_cycle <= ~odd_cycle; // Even and odd ticks alternate
		end
	end

	// Ticks never run back to back
	a_ce_single: assert property (@(posedge clk) disable iff (reset)
		cpu_ce |=> !cpu_ce);

endmodule

// ==== dma_controller.sv ====
// Handles one DMC request at a time. The CPU must read on the odd tick that starts or resumes sprite DMA.
`timescale 1ns/1ps

module dma_controller (
	input  logic                clk,
	input  logic                reset,
	input  logic                cpu_ce,
	input  logic                odd_cycle,
	input  logic                sprite_trigger, // Write to the sprite DMA register this tick
	input  nes_bus_pkg::addr_t  cpu_addr,
	input  nes_bus_pkg::byte_t  cpu_wdata,
	input  logic                cpu_rnw,        // 1 while the CPU reads
	input  nes_bus_pkg::byte_t  read_data,      // Byte on the bus this tick
	input  logic                dmc_req,        // Held by the APU until dmc_ack
	input  nes_bus_pkg::addr_t  dmc_addr,
	output logic                dmc_ack,
	output logic                pause_cpu,
	output logic                dma_active,     // DMA owns the bus this tick
	cpu_bus_if.master           bus
);

	import nes_bus_pkg::*;

	logic       dmc_pending; // DMC fetch granted and waiting for its even tick
	spr_state_t spr_state;
	byte_t      spr_page;    // High byte of the source
	byte_t      spr_index;   // Low byte of the source and count of pairs done
	byte_t      spr_data;    // Byte read on the last DMA tick
	addr_t      dma_addr;

	// DMC fetch always lands on an even tick
	assign dmc_ack = dmc_pending && !odd_cycle;

	// The CPU stays held from the arm until the last write
	// and also while a DMC request waits
	assign pause_cpu  = (spr_state != SPR_IDLE) || dmc_req;
	assign dma_active = dmc_ack || (spr_state == SPR_ACTIVE);

	// DMC beats sprite, sprite reads even and writes odd
	assign dma_addr = dmc_ack    ? dmc_addr :
	                  !odd_cycle ? {spr_page, spr_index} :
	                               OAM_DATA_ADDR;

	// Bus merge
	assign bus.addr  = dma_active ? dma_addr : cpu_addr;
	assign bus.wdata = dma_active ? spr_data : cpu_wdata;
	assign bus.rd    = dma_active ? !odd_cycle : cpu_rnw;
	assign bus.wr    = dma_active ? odd_cycle : !cpu_rnw;

	always_ff @(posedge clk) begin
		if (reset) begin
			dmc_pending <= 1'b0;
			spr_state   <= SPR_IDLE;
			spr_index   <= '0;
		end else if (cpu_ce) begin
			// DMC grant on an even CPU read tick, the fetch follows two ticks later
			if (dmc_ack)
				dmc_pending <= 1'b0;
			else if (dmc_req && cpu_rnw && !odd_cycle)
				dmc_pending <= 1'b1;

			case (spr_state)
				SPR_IDLE: begin
					spr_state <= SPR_IDLE;
				end
				SPR_ARMED: begin
					if (odd_cycle && cpu_rnw) // Next tick is even and reads
						spr_state <= SPR_ACTIVE;
				end
				SPR_ACTIVE: begin
					if (dmc_ack) begin
						spr_state <= SPR_ARMED; // Lose the even tick, idle on the odd one
					end else if (odd_cycle) begin
						spr_index <= spr_index + 1'b1; // Pair done
						if (spr_index == 8'hff)
							spr_state <= SPR_IDLE; // 256th write
					end
				end
				default: spr_state <= SPR_IDLE;
			endcase

			// Trigger wins over everything else
			if (sprite_trigger) begin
				spr_state <= SPR_ARMED;
				spr_index <= '0;
			end
		end
	end

	// Source page and the byte in flight
	always_ff @(posedge clk) begin
		if (cpu_ce) begin
			if (sprite_trigger)
				spr_page <= cpu_wdata;
			if (spr_state == SPR_ACTIVE)
				spr_data <= read_data; // Odd write sends what the even tick read
		end
	end

	// APU keeps its request up through the fetch tick
	a_dmc_held: assert property (@(posedge clk) disable iff (reset)
		dmc_ack |-> dmc_req);

endmodule

// ==== bus_address_decode.sv ====
// Decodes full 16-bit addresses with no mirrors. joypad_clock is a one-clock pulse after the read tick.
`timescale 1ns/1ps

module bus_address_decode (
	input  logic                                  clk,
	input  logic                                  reset,
	input  logic                                  cpu_ce,
	cpu_bus_if.observer                           bus,
	output logic                                  sprite_trigger, // Write to the sprite DMA register
	output logic                                  apu_cs,
	output logic                                  ppu_cs,
	output logic                                  joy1_cs,
	output logic                                  joy2_cs,
	output logic [nes_bus_pkg::JOY_OUT_BITS-1:0]  joypad_out,     // Strobe latch
	output logic [1:0]                            joypad_clock    // Bit 0 port 1, bit 1 port 2
);

	import nes_bus_pkg::*;

	// Register windows
	assign apu_cs  = (bus.addr >= APU_BASE) && (bus.addr < APU_END);
	assign ppu_cs  = (bus.addr >= PPU_BASE) && (bus.addr < PPU_END);
	assign joy1_cs = (bus.addr == JOY1_ADDR);
	assign joy2_cs = (bus.addr == JOY2_ADDR);

	// DMA controller samples this on cpu_ce
	assign sprite_trigger = bus.wr && (bus.addr == SPRITE_DMA_ADDR);

	always_ff @(posedge clk) begin
		if (reset) begin
			joypad_out   <= '0;
			joypad_clock <= 2'b00;
		end else begin
			// Pulse only once per read tick
			joypad_clock <= 2'b00;
			if (cpu_ce) begin
				if (joy1_cs && bus.wr)
					joypad_out <= bus.wdata[JOY_OUT_BITS-1:0]; // Low bits hold the strobe
				if (bus.rd)
					joypad_clock <= {joy2_cs, joy1_cs}; // Shift the addressed pad
			end
		end
	end

endmodule

// ==== read_data_mux.sv ====
// There is no cartridge, so anything outside the APU and PPU windows reads ram_data. The open bus is 0 after reset.
`timescale 1ns/1ps

module read_data_mux (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              cpu_ce,
	cpu_bus_if.observer                       bus,
	input  logic                              apu_cs,
	input  logic                              ppu_cs,
	input  logic                              joy1_cs,
	input  logic                              joy2_cs,
	input  logic [nes_bus_pkg::JOY_BITS-1:0]  joypad1_data,
	input  logic [nes_bus_pkg::JOY_BITS-1:0]  joypad2_data,
	input  nes_bus_pkg::byte_t                apu_status,
	input  nes_bus_pkg::byte_t                ppu_data,
	input  nes_bus_pkg::byte_t                ram_data,
	output nes_bus_pkg::byte_t                read_data
);

	import nes_bus_pkg::*;

	byte_t open_bus; // Last byte seen on the bus

	// Priority follows the register map
	always_comb begin
		if (joy1_cs)
			read_data = {open_bus[7:JOY_BITS], joypad1_data}; // Pad drives the low bits only
		else if (joy2_cs)
			read_data = {open_bus[7:JOY_BITS], joypad2_data};
		else if (bus.addr == APU_STATUS_ADDR)
			read_data = apu_status;
		else if (apu_cs)
			read_data = open_bus; // Write-only APU registers
		else if (ppu_cs)
			read_data = ppu_data;
		else
			read_data = ram_data;
	end

	// Bus capacitance holds the last value for one tick
	always_ff @(posedge clk) begin
		if (reset)
			open_bus <= '0;
		else if (cpu_ce)
			open_bus <= read_data;
	end

endmodule

// ==== nes_bus_top.sv ====
// CPU_DIV must be even and at least 2. The CPU must read while it is paused and must hold dmc_req until dmc_ack.
`timescale 1ns/1ps

module nes_bus_top #(
	parameter int CPU_DIV = nes_bus_pkg::CPU_DIV_DEFAULT
) (
	input  logic                                  clk,
	input  logic                                  reset,
	input  nes_bus_pkg::addr_t                    cpu_addr,
	input  nes_bus_pkg::byte_t                    cpu_wdata,
	input  logic                                  cpu_rnw,
	input  logic                                  dmc_req,
	input  nes_bus_pkg::addr_t                    dmc_addr,
	input  nes_bus_pkg::byte_t                    ram_data,
	input  nes_bus_pkg::byte_t                    apu_status,
	input  nes_bus_pkg::byte_t                    ppu_data,
	input  logic [nes_bus_pkg::JOY_BITS-1:0]      joypad1_data,
	input  logic [nes_bus_pkg::JOY_BITS-1:0]      joypad2_data,
	output nes_bus_pkg::addr_t                    bus_addr,
	output nes_bus_pkg::byte_t                    bus_wdata,
	output logic                                  bus_read,
	output logic                                  bus_write,
	output nes_bus_pkg::byte_t                    read_data,
	output logic                                  pause_cpu,
	output logic                                  dmc_ack,
	output logic [nes_bus_pkg::JOY_OUT_BITS-1:0]  joypad_out,
	output logic [1:0]                            joypad_clock
);

	logic cpu_ce;
	logic odd_cycle;
	logic sprite_trigger;
	logic apu_cs;
	logic ppu_cs;
	logic joy1_cs;
	logic joy2_cs;

	cpu_bus_if bus (); // Merged bus after DMA

	cpu_clock_divider #(
		.CPU_DIV (CPU_DIV)
	) u_clk_div (
		.clk       (clk),
		.reset     (reset),
		.cpu_ce    (cpu_ce),
		.odd_cycle (odd_cycle)
	);

	dma_controller u_dma (
		.clk            (clk),
		.reset          (reset),
		.cpu_ce         (cpu_ce),
		.odd_cycle      (odd_cycle),
		.sprite_trigger (sprite_trigger),
		.cpu_addr       (cpu_addr),
		.cpu_wdata      (cpu_wdata),
		.cpu_rnw        (cpu_rnw),
		.read_data      (read_data),
		.dmc_req        (dmc_req),
		.dmc_addr       (dmc_addr),
		.dmc_ack        (dmc_ack),
		.pause_cpu      (pause_cpu),
		.dma_active     (),            // Only the bus merge needs it
		.bus            (bus.master)
	);

	bus_address_decode u_decode (
		.clk            (clk),
		.reset          (reset),
		.cpu_ce         (cpu_ce),
		.bus            (bus.observer),
		.sprite_trigger (sprite_trigger),
		.apu_cs         (apu_cs),
		.ppu_cs         (ppu_cs),
		.joy1_cs        (joy1_cs),
		.joy2_cs        (joy2_cs),
		.joypad_out     (joypad_out),
		.joypad_clock   (joypad_clock)
	);

	read_data_mux u_rdata (
		.clk          (clk),
		.reset        (reset),
		.cpu_ce       (cpu_ce),
		.bus          (bus.observer),
		.apu_cs       (apu_cs),
		.ppu_cs       (ppu_cs),
		.joy1_cs      (joy1_cs),
		.joy2_cs      (joy2_cs),
		.joypad1_data (joypad1_data),
		.joypad2_data (joypad2_data),
		.apu_status   (apu_status),
		.ppu_data     (ppu_data),
		.ram_data     (ram_data),
		.read_data    (read_data)
	);

	// Merged bus to the memory side
	assign bus_addr  = bus.addr;
	assign bus_wdata = bus.wdata;
	assign bus_read  = bus.rd;
	assign bus_write = bus.wr;

endmodule

// ==== tb_clock_gen.sv ====
// Free-running testbench clock. Reset is released on the rising edge after RESET_CYCLES edges.
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter real PERIOD       = 100.0, // ns
	parameter int  RESET_CYCLES = 4
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2.0) clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0; // Released on a rising edge
	end

endmodule

// ==== tb_checker.sv ====
// Assumes ticks start right after reset falls and that the RAM model returns high XOR low address byte.
`timescale 1ns/1ps

module tb_checker #(
	parameter int CPU_DIV = 12
) (
	input  logic           clk,
	input  logic           reset,
	input  logic [15:0]    bus_addr,
	input  logic [7:0]     bus_wdata,
	input  logic           bus_read,
	input  logic           bus_write,
	input  logic [7:0]     read_data,
	input  logic           pause_cpu,
	input  logic           dmc_ack,
	input  logic [15:0]    dmc_addr,
	input  logic [2:0]     joypad_out,
	input  logic [1:0]     joypad_clock,
	input  logic           rec_start,  // First clock of a record
	input  logic           rec_end,    // First clock after a record
	input  logic [8*16-1:0] rec_name,
	input  logic [1:0]     rec_kind,   // 0 read, 1 write, 2 sprite DMA, 3 sprite DMA with DMC
	input  logic [7:0]     rec_data,
	input  logic [7:0]     rec_exp,
	input  logic [1:0]     exp_jclk,
	input  logic [2:0]     exp_jout,
	output int             err_count,
	output int             chk_count
);

	int             tick_cnt;   // Master clocks into the tick
	int             rec_ticks;  // Ticks since the record began
	int             wr_cnt;     // OAM writes seen
	int             rd_cnt;     // Sprite source reads seen
	int             ack_cnt;
	logic [8*16-1:0] name_q;
	logic [1:0]     kind_q = 2'd0;
	logic [7:0]     page_q;
	logic [7:0]     exp_q;
	logic [1:0]     jclk_q;
	logic [2:0]     jout_q;

	initial begin
		err_count = 0;
		chk_count = 0;
	end

	task automatic check_value(input string what, input logic [15:0] expv,
		input logic [15:0] actv);
		chk_count++;
		if (expv !== actv) begin
			err_count++;
			$display("** Error %0s %0s expected %h actual %h", name_q, what, expv, actv);
		end
	endtask

	always @(posedge clk) begin
		if (reset) begin
			tick_cnt = 0;
		end else begin
			// Wrap-up of the record that just ended, joypad_clock pulse still visible
			if (rec_end) begin
				if (kind_q >= 2'd2) begin
					check_value("oam writes", 16'd256, wr_cnt[15:0]);
					check_value("source reads", 16'd256, rd_cnt[15:0]);
				end
				check_value("dmc acks", {15'd0, kind_q == 2'd3}, ack_cnt[15:0]);
				check_value("joypad_out", {13'd0, jout_q}, {13'd0, joypad_out});
				check_value("joypad_clock", {14'd0, jclk_q}, {14'd0, joypad_clock});
			end
			if (rec_start) begin
				name_q    = rec_name;
				kind_q    = rec_kind;
				page_q    = rec_data; // Sprite page for DMA records
				exp_q     = rec_exp;
				jclk_q    = exp_jclk;
				jout_q    = exp_jout;
				rec_ticks = 0;
				wr_cnt    = 0;
				rd_cnt    = 0;
				ack_cnt   = 0;
			end
			// Tick end, everything is stable here
			if (tick_cnt == CPU_DIV - 1) begin
				if (dmc_ack) begin
					ack_cnt++;
					check_value("dmc ack address", dmc_addr, bus_addr);
				end
				if (kind_q == 2'd0 && rec_ticks == 0)
					check_value("read_data", {8'd0, exp_q}, {8'd0, read_data});
				if (kind_q >= 2'd2 && rec_ticks > 0) begin
					if (wr_cnt < 256)
						check_value("pause_cpu held", 16'd1, {15'd0, pause_cpu});
					else
						check_value("pause_cpu after dma", 16'd0, {15'd0, pause_cpu});
					if (bus_write && bus_addr == 16'h2004) begin
						check_value("oam write data", {8'd0, page_q ^ wr_cnt[7:0]},
							{8'd0, bus_wdata});
						wr_cnt++;
					end
					if (bus_read && !dmc_ack && bus_addr[15:8] == page_q) begin
						check_value("source address", {page_q, rd_cnt[7:0]}, bus_addr);
						rd_cnt++;
					end
				end
				rec_ticks++;
			end
			tick_cnt = (tick_cnt == CPU_DIV - 1) ? 0 : tick_cnt + 1;
		end
	end

endmodule

// ==== tb_nes_bus.sv ====
// Records come from dma_input.txt in the project root. The CPU reads 2002 while it is paused.
`timescale 1ns/1ps

module tb_nes_bus;
	import nes_bus_pkg::*;

	localparam int CPU_DIV  = CPU_DIV_DEFAULT;
	localparam int MAX_RECS = 64;

	logic        clk, reset;
	addr_t       cpu_addr, dmc_addr, bus_addr;
	byte_t       cpu_wdata, ram_data, apu_status, ppu_data, bus_wdata, read_data;
	logic        cpu_rnw, dmc_req, bus_read, bus_write, pause_cpu, dmc_ack;
	logic [4:0]  joypad1_data, joypad2_data;
	logic [2:0]  joypad_out, exp_jout;
	logic [1:0]  joypad_clock, exp_jclk, rec_kind;
	logic        rec_start, rec_end;
	logic [8*16-1:0] rec_name;
	byte_t       rec_data, rec_exp;
	int          err_count, chk_count;

	logic [8*16-1:0] names [MAX_RECS];
	int          kinds [MAX_RECS];
	addr_t       addrs [MAX_RECS];
	byte_t       datas [MAX_RECS];
	byte_t       exps  [MAX_RECS];
	int          n_recs;
	int          cycles = 0;
	int          limit  = 32'h7fffffff; // Set once the records are known
	logic [31:0] lcg_state = 32'hac39;

	tb_clock_gen u_clk (.clk(clk), .reset(reset));

	nes_bus_top #(.CPU_DIV(CPU_DIV)) UUT (
		.clk(clk), .reset(reset), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
		.cpu_rnw(cpu_rnw), .dmc_req(dmc_req), .dmc_addr(dmc_addr), .ram_data(ram_data),
		.apu_status(apu_status), .ppu_data(ppu_data), .joypad1_data(joypad1_data),
		.joypad2_data(joypad2_data), .bus_addr(bus_addr), .bus_wdata(bus_wdata),
		.bus_read(bus_read), .bus_write(bus_write), .read_data(read_data),
		.pause_cpu(pause_cpu), .dmc_ack(dmc_ack), .joypad_out(joypad_out),
		.joypad_clock(joypad_clock)
	);

	tb_checker #(.CPU_DIV(CPU_DIV)) u_check (
		.clk(clk), .reset(reset), .bus_addr(bus_addr), .bus_wdata(bus_wdata),
		.bus_read(bus_read), .bus_write(bus_write), .read_data(read_data),
		.pause_cpu(pause_cpu), .dmc_ack(dmc_ack), .dmc_addr(dmc_addr),
		.joypad_out(joypad_out), .joypad_clock(joypad_clock), .rec_start(rec_start),
		.rec_end(rec_end), .rec_name(rec_name), .rec_kind(rec_kind), .rec_data(rec_data),
		.rec_exp(rec_exp), .exp_jclk(exp_jclk), .exp_jout(exp_jout),
		.err_count(err_count), .chk_count(chk_count)
	);

	assign ram_data = bus_addr[7:0] ^ bus_addr[15:8]; // RAM model

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// One CPU tick, entered and left on a falling edge
	task automatic run_tick(input addr_t a, input byte_t d, input logic rnw,
		output logic acked);
		cpu_addr  = a;
		cpu_wdata = d;
		cpu_rnw   = rnw;
		@(negedge clk);
		rec_start = 1'b0; // Record strobes last one clock
		rec_end   = 1'b0;
		repeat (CPU_DIV - 2) @(negedge clk);
		acked = dmc_ack; // Last look before the cpu_ce edge of the tick
		@(negedge clk);
	endtask

	task automatic load_records();
		int fd, n, k, ticks;
		logic [8*96-1:0] line;
		logic [8*16-1:0] nm;
		logic [15:0] a;
		logic [7:0] d, e;
		n_recs = 0;
		ticks  = 0;
		fd = $fopen("dma_input.txt", "r");
		if (fd != 0) begin
			while (!$feof(fd) && n_recs < MAX_RECS) begin
				line = '0;
				void'($fgets(line, fd));
				n = $sscanf(line, "%s %d %h %h %h", nm, k, a, d, e); // Comments fall short
				if (n == 5) begin
					names[n_recs] = nm;
					kinds[n_recs] = k;
					addrs[n_recs] = a;
					datas[n_recs] = d;
					exps[n_recs]  = e;
					ticks += (k >= 2) ? 600 : 4;
					n_recs++;
				end
			end
			$fclose(fd);
		end
		limit = ticks * CPU_DIV + 16; // Plus reset
	endtask

	task automatic run_records();
		int t, delay;
		logic [2:0] joy_model;
		logic acked;
		joy_model = 3'd0;
		for (int i = 0; i < n_recs; i++) begin
			rec_name  = names[i];
			rec_kind  = kinds[i][1:0];
			rec_data  = datas[i];
			rec_exp   = exps[i];
			exp_jclk  = (kinds[i] == 0) ? {addrs[i] == JOY2_ADDR, addrs[i] == JOY1_ADDR} : 2'b00;
			if (kinds[i] == 1 && addrs[i] == JOY1_ADDR)
				joy_model = exps[i][2:0];
			exp_jout  = joy_model;
			rec_start = 1'b1;
			rec_end   = (i > 0);
			if (kinds[i] == 3) begin
				lcg_state = lcg_next(lcg_state);
				delay     = 20 + (lcg_state[24:16] % 400); // Ticks into the DMA
				lcg_state = lcg_next(lcg_state);
				dmc_addr  = {2'b11, lcg_state[29:16]};
			end
			run_tick(addrs[i], datas[i], kinds[i] == 0, acked);
			// Keep reading while the DMA holds the CPU
			t = 0;
			while (kinds[i] >= 2 && pause_cpu) begin
				if (acked)
					dmc_req = 1'b0; // Handshake done
				else if (kinds[i] == 3 && t == delay)
					dmc_req = 1'b1;
				run_tick(16'h2002, 8'h00, 1'b1, acked);
				t++;
			end
		end
		rec_start = 1'b0;
		rec_end   = 1'b1;
		@(negedge clk);
		rec_end = 1'b0;
		@(negedge clk);
	endtask

	// Hang guard
	always @(posedge clk) begin
		cycles++;
		if (cycles > limit) begin
			$display("Timeout, the run did not finish within %0d clock cycles", limit);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	initial begin
		cpu_addr     = 16'h0000;
		cpu_wdata    = 8'h00;
		cpu_rnw      = 1'b1;
		dmc_req      = 1'b0;
		dmc_addr     = 16'hc000;
		apu_status   = 8'h3c;
		ppu_data     = 8'ha7;
		joypad1_data = 5'h15;
		joypad2_data = 5'h0a;
		rec_start    = 1'b0;
		rec_end      = 1'b0;
		rec_name     = '0;
		rec_kind     = 2'd0;
		rec_data     = 8'h00;
		rec_exp      = 8'h00;
		exp_jclk     = 2'b00;
		exp_jout     = 3'd0;
		load_records();
		@(negedge clk);
		while (reset) @(negedge clk); // First tick starts here
		if (n_recs == 0) begin
			$display("No test records could be read from dma_input.txt");
			$display("STATUS: FAIL");
		end else begin
			run_records();
			$display("Records: %0d, checks: %0d, errors: %0d", n_recs, chk_count, err_count);
			if (err_count == 0 && chk_count > 0)
				$display("STATUS: PASS");
			else
				$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// ==== dma_input.txt ====
# name kind addr data expected (hex), expected is read_data or joypad_out after a write
# kind 0 cpu read, 1 cpu write, 2 sprite DMA, 3 sprite DMA with DMC request
rd_ram 0 0123 00 22
rd_apu_status 0 4015 00 3c
rd_ppu 0 2002 00 a7
rd_joy1 0 4016 00 b5
wr_joy1 1 4016 05 05
rd_joy2 0 4017 00 aa
rd_apu_open 0 4000 00 aa
dma_page02 2 4014 02 00
rd_ram_hi 0 c3a5 00 66
dma_dmc_page85 3 4014 85 00
rd_joy1_after 0 4016 00 b5
wr_joy1_low 1 4016 02 02
dma_dmc_page1f 3 4014 1f 00
rd_vector 0 fffc 00 03

// ==== sim.f ====
nes_bus_pkg.sv
cpu_bus_if.sv
cpu_clock_divider.sv
dma_controller.sv
bus_address_decode.sv
read_data_mux.sv
nes_bus_top.sv
tb_clock_gen.sv
tb_checker.sv
tb_nes_bus.sv

// ==== Bender.yml ====
package:
  name: nes_bus

sources:
  - nes_bus_pkg.sv
  - cpu_bus_if.sv
  - cpu_clock_divider.sv
  - dma_controller.sv
  - bus_address_decode.sv
  - read_data_mux.sv
  - nes_bus_top.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - tb_checker.sv
      - tb_nes_bus.sv
